//--- hw/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // Keypad code width, one decimal digit per strobe
    localparam int DIGIT_W = 4;

    // Operand and result width unless the top level overrides it
    localparam int DEFAULT_DATA_W = 16;

    typedef logic [2:0] op_t;

    // One-hot operator codes from the keypad
    localparam op_t OP_ADD = 3'b001;
    localparam op_t OP_SUB = 3'b010;
    localparam op_t OP_MUL = 3'b100;

endpackage

`default_nettype wire

//--- hw/keypad_entry.sv
`default_nettype none

module keypad_entry #(
    parameter int DATA_W = calc_pkg::DEFAULT_DATA_W
) (
    input  wire                         clk,
    input  wire                         nRST,
    input  wire [calc_pkg::DIGIT_W-1:0] keypad_input,
    input  wire                         read_input,    // One cycle per digit
    input  wire                         entry_enable,
    input  wire                         entry_second,  // Low selects operand_a
    input  wire                         entry_clear,
    output logic [DATA_W-1:0]           operand_a,
    output logic [DATA_W-1:0]           operand_b
);
    import calc_pkg::*;

    logic [DATA_W-1:0] selected;
    logic [DATA_W-1:0] digit_ext;
    logic [DATA_W-1:0] accumulated;
    logic              digit_take;

    // Codes 10 to 15 are not digits
    assign digit_take = read_input && entry_enable && (keypad_input < DIGIT_W'(10));

    assign selected  = entry_second ? operand_b : operand_a;
    assign digit_ext = {{(DATA_W - DIGIT_W){1'b0}}, keypad_input};

    // x*10 as x*8 + x*2, wraps at DATA_W
    assign accumulated = (selected << 3) + (selected << 1) + digit_ext;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand_a <= '0;
            operand_b <= '0;
        end else if (entry_clear) begin
            operand_a <= '0;  // Fresh start for next operation
            operand_b <= '0;
        end else if (digit_take) begin
            if (entry_second) begin
                operand_b <= accumulated;
            end else begin
                operand_a <= accumulated;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/calc_sequencer.sv
`default_nettype none

module calc_sequencer (
    input  wire                 clk,
    input  wire                 nRST,
    input  wire calc_pkg::op_t  operator_input,  // Sampled as a level
    input  wire                 equal_input,
    input  wire                 add_sub_finish,
    input  wire                 mult_finish,
    output logic                entry_enable,
    output logic                entry_second,
    output logic                entry_clear,
    output logic                start_add_sub,
    output logic                subtract,
    output logic                start_mult
);
    import calc_pkg::*;

    typedef enum logic [2:0] {
        FIRST  = 3'd0,  // First operand digits
        SECOND = 3'd1,  // Second operand digits
        ISSUE  = 3'd2,  // Fire the selected unit
        WAIT   = 3'd3,
        SHOW   = 3'd4
    } state_t;

    state_t state;
    state_t next_state;
    op_t    op_reg;
    logic   op_valid;
    logic   unit_done;

    // Anything but the three one-hot codes is ignored
    assign op_valid = (operator_input == OP_ADD) ||
                      (operator_input == OP_SUB) ||
                      (operator_input == OP_MUL);

    assign unit_done = add_sub_finish || mult_finish;

    always_comb begin
        next_state = state;
        case (state)
            FIRST: begin
                if (op_valid) begin
                    next_state = SECOND;
                end
            end
            SECOND: begin
                if (equal_input) begin
                    next_state = ISSUE;
                end
            end
            ISSUE: begin
                next_state = WAIT;
            end
            WAIT: begin
                if (unit_done) begin
                    next_state = SHOW;
                end
            end
            SHOW: begin
                next_state = FIRST;
            end
            default: begin
                next_state = FIRST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state         <= FIRST;
            op_reg        <= OP_ADD;
            start_add_sub <= 1'b0;
            start_mult    <= 1'b0;
        end else begin
            state <= next_state;
            if ((state == FIRST) && op_valid) begin
                op_reg <= operator_input;  // Held through the operation
            end
            // Registered start, high for the single cycle after ISSUE
            start_add_sub <= (state == ISSUE) && (op_reg != OP_MUL);
            start_mult    <= (state == ISSUE) && (op_reg == OP_MUL);
        end
    end

    assign subtract     = (op_reg == OP_SUB);
    assign entry_enable = (state == FIRST) || (state == SECOND);
    assign entry_second = (state == SECOND);

    // Operands are cleared on the edge that leaves SHOW
    assign entry_clear = (state == SHOW);

endmodule

`default_nettype wire

//--- hw/serial_add_sub.sv
`default_nettype none

module serial_add_sub #(
    parameter int DATA_W = calc_pkg::DEFAULT_DATA_W
) (
    input  wire              clk,
    input  wire              nRST,
    input  wire              start,
    input  wire              subtract,  // Valid with start
    input  wire [DATA_W-1:0] in_a,
    input  wire [DATA_W-1:0] in_b,
    output logic [DATA_W-1:0] result,
    output logic              finish
);
    localparam int CNT_W = $clog2(DATA_W);

    logic [DATA_W-1:0] a_shift;
    logic [DATA_W-1:0] b_shift;
    logic              carry;
    logic              sum_bit;
    logic              busy;
    logic              last_step;
    logic [CNT_W-1:0]  step;

    assign sum_bit   = a_shift[0] ^ b_shift[0] ^ carry;
    assign last_step = busy && (step == CNT_W'(DATA_W - 1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= last_step;  // Exactly one pulse per start
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // LSB first, sum bits enter result from the top
    always_ff @(posedge clk) begin
        if (start) begin
            a_shift <= in_a;
            b_shift <= subtract ? ~in_b : in_b;  // a + ~b + 1 for a - b
            carry   <= subtract;
        end else if (busy) begin
            a_shift <= a_shift >> 1;
            b_shift <= b_shift >> 1;
            carry   <= (a_shift[0] & b_shift[0]) | (carry & (a_shift[0] ^ b_shift[0]));
            result  <= {sum_bit, result[DATA_W-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- hw/shift_add_multiplier.sv
`default_nettype none

module shift_add_multiplier #(
    parameter int DATA_W = calc_pkg::DEFAULT_DATA_W
) (
    input  wire              clk,
    input  wire              nRST,
    input  wire              start,
    input  wire [DATA_W-1:0] in_a,  // Multiplicand
    input  wire [DATA_W-1:0] in_b,  // Multiplier
    output logic [DATA_W-1:0] result,
    output logic              finish
);
    localparam int CNT_W = $clog2(DATA_W);

    logic [DATA_W-1:0] mcand;
    logic [DATA_W-1:0] mplier;
    logic              busy;
    logic              last_step;
    logic [CNT_W-1:0]  step;

    assign last_step = busy && (step == CNT_W'(DATA_W - 1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= last_step;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Only the low DATA_W product bits are kept, so the
    // multiplicand simply shifts out of range at the top
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= in_a;
            mplier <= in_b;
            result <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                result <= result + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;  // Next multiplier bit to [0]
        end
    end

endmodule

`default_nettype wire

//--- hw/result_display.sv
`default_nettype none

module result_display #(
    parameter int DATA_W = calc_pkg::DEFAULT_DATA_W
) (
    input  wire                      clk,
    input  wire                      nRST,
    input  wire                      add_sub_finish,
    input  wire [DATA_W-1:0]         add_sub_result,
    input  wire                      mult_finish,
    input  wire [DATA_W-1:0]         mult_result,
    output logic signed [DATA_W-1:0] display_output,
    output logic                     complete
);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_output <= '0;
            complete       <= 1'b0;
        end else begin
            complete <= add_sub_finish || mult_finish;  // One cycle wide
            if (add_sub_finish) begin
                display_output <= $signed(add_sub_result);
            end else if (mult_finish) begin
                display_output <= $signed(mult_result);
            end
            // Otherwise hold the last result
        end
    end

endmodule

`default_nettype wire

//--- hw/calculator_top.sv
`default_nettype none

module calculator_top #(
    parameter int DATA_W = calc_pkg::DEFAULT_DATA_W
) (
    input  wire                         clk,
    input  wire                         nRST,
    input  wire [calc_pkg::DIGIT_W-1:0] keypad_input,
    input  wire                         read_input,
    input  wire calc_pkg::op_t          operator_input,
    input  wire                         equal_input,
    output wire signed [DATA_W-1:0]     display_output,
    output wire                         complete
);

    wire [DATA_W-1:0] operand_a;
    wire [DATA_W-1:0] operand_b;
    wire              entry_enable;
    wire              entry_second;
    wire              entry_clear;
    wire              start_add_sub;
    wire              subtract;
    wire              start_mult;
    wire [DATA_W-1:0] add_sub_result;
    wire              add_sub_finish;
    wire [DATA_W-1:0] mult_result;
    wire              mult_finish;

    keypad_entry #(.DATA_W(DATA_W)) u_entry (
        .clk          (clk),
        .nRST         (nRST),
        .keypad_input (keypad_input),
        .read_input   (read_input),
        .entry_enable (entry_enable),
        .entry_second (entry_second),
        .entry_clear  (entry_clear),
        .operand_a    (operand_a),
        .operand_b    (operand_b)
    );

    calc_sequencer u_seq (
        .clk            (clk),
        .nRST           (nRST),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .add_sub_finish (add_sub_finish),
        .mult_finish    (mult_finish),
        .entry_enable   (entry_enable),
        .entry_second   (entry_second),
        .entry_clear    (entry_clear),
        .start_add_sub  (start_add_sub),
        .subtract       (subtract),
        .start_mult     (start_mult)
    );

    serial_add_sub #(.DATA_W(DATA_W)) u_add_sub (
        .clk      (clk),
        .nRST     (nRST),
        .start    (start_add_sub),
        .subtract (subtract),
        .in_a     (operand_a),
        .in_b     (operand_b),
        .result   (add_sub_result),
        .finish   (add_sub_finish)
    );

    shift_add_multiplier #(.DATA_W(DATA_W)) u_mult (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_mult),
        .in_a   (operand_a),
        .in_b   (operand_b),
        .result (mult_result),
        .finish (mult_finish)
    );

    result_display #(.DATA_W(DATA_W)) u_display (
        .clk            (clk),
        .nRST           (nRST),
        .add_sub_finish (add_sub_finish),
        .add_sub_result (add_sub_result),
        .mult_finish    (mult_finish),
        .mult_result    (mult_result),
        .display_output (display_output),
        .complete       (complete)
    );

endmodule

`default_nettype wire

//--- dv/calculator_tb.sv
`default_nettype none

module calculator_tb;
    import calc_pkg::*;

    localparam int DATA_W         = 16;
    localparam int CLK_PERIOD     = 4;
    localparam int FIXED_OPS      = 10;
    localparam int RANDOM_OPS     = 200;
    localparam int TIMEOUT_CYCLES = (FIXED_OPS + RANDOM_OPS) * 60 + 200;

    logic                    clk = 1'b0;
    logic                    nRST;
    logic [DIGIT_W-1:0]      keypad_input;
    logic                    read_input;
    op_t                     operator_input;
    logic                    equal_input;
    wire signed [DATA_W-1:0] display_output;
    wire                     complete;

    logic [DATA_W-1:0] exp_values[$];  // Pending results, oldest first
    string             exp_names[$];
    int                exp_cycles[$];  // Cycle in which complete must rise
    int                cycle_count   = 0;
    int                issued_count  = 0;
    int                done_count    = 0;
    logic [DATA_W-1:0] held_value    = '0;
    logic              prev_complete = 1'b0;
    logic              was_high;

    calculator_top #(.DATA_W(DATA_W)) uut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .display_output (display_output),
        .complete       (complete)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [DATA_W-1:0] calc_expected(input logic [DATA_W-1:0] a,
                                                        input logic [DATA_W-1:0] b,
                                                        input op_t op);
        logic [2*DATA_W-1:0] product;
        product = a * b;
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            default: return product[DATA_W-1:0];  // Low half only
        endcase
    endfunction

    function automatic int unsigned random_operand();
        int ndigits;
        ndigits = $urandom_range(1, 5);
        return $urandom_range(0, 10 ** ndigits - 1);
    endfunction

    function automatic op_t random_operator();
        case ($urandom_range(0, 2))
            0:       return OP_ADD;
            1:       return OP_SUB;
            default: return OP_MUL;
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            abort_run("Wrong value seen on the DUT outputs");
        end
    endtask

    // Inputs change 1 time unit after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic press_key(input logic [DIGIT_W-1:0] code);
        keypad_input = code;
        read_input   = 1'b1;
        tick();
        read_input   = 1'b0;
        idle($urandom_range(1, 2));
    endtask

    // Decimal digits MSB first, optionally with a junk code after each one
    task automatic enter_number(input int unsigned value, input bit junk,
                                output logic [DATA_W-1:0] model);
        int unsigned div;
        int unsigned digit;
        div   = 1;
        model = '0;
        while (div * 10 <= value) div = div * 10;
        while (div > 0) begin
            digit = (value / div) % 10;
            press_key(DIGIT_W'(digit));
            model = model * DATA_W'(10) + DATA_W'(digit);
            if (junk) begin
                press_key(DIGIT_W'($urandom_range(10, 15)));
            end
            div = div / 10;
        end
    endtask

    task automatic press_operator(input op_t op);
        operator_input = op;
        tick();
        operator_input = '0;  // Level must drop or the next FIRST would latch it
        idle($urandom_range(0, 2));
    endtask

    task automatic pulse_equal();
        equal_input = 1'b1;
        tick();
        equal_input = 1'b0;
    endtask

    task automatic run_operation(input string name, input int unsigned a, input int unsigned b,
                                 input op_t op, input bit junk, input bit bad_op,
                                 input bit early_equal);
        logic [DATA_W-1:0] a_model;
        logic [DATA_W-1:0] b_model;
        if (early_equal) begin
            pulse_equal();  // Not in SECOND, so no result may follow
            idle(2);
        end
        enter_number(a, junk, a_model);
        if (bad_op) begin
            press_operator(op_t'(3'b011));
        end
        press_operator(op);
        enter_number(b, junk, b_model);
        pulse_equal();
        exp_values.push_back(calc_expected(a_model, b_model, op));
        exp_names.push_back(name);
        exp_cycles.push_back(cycle_count + DATA_W + 3);
        issued_count++;
        wait (done_count == issued_count);
        idle(2);  // Sequencer back in FIRST with cleared operands
    endtask

    always @(negedge clk) begin
        was_high      = prev_complete;
        prev_complete = complete;
        if (complete === 1'b1) begin
            if (was_high) begin
                abort_run("The complete pulse stayed high for more than one cycle");
            end else if (exp_values.size() == 0) begin
                abort_run("The complete pulse came with no operation pending");
            end else begin
                check({exp_names[0], " result"}, 32'(exp_values.pop_front()),
                      32'($unsigned(display_output)));
                check({exp_names[0], " timing"}, exp_cycles.pop_front(), cycle_count);
                exp_names.delete(0);
                held_value = display_output;
                done_count++;
            end
        end else begin
            check("display hold", 32'(held_value), 32'($unsigned(display_output)));
            check("complete low", 32'd0, 32'(complete));
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abort_run("Timeout: the operations did not finish in the expected time");
    end

    initial begin : stimulus
        string name;
        void'($urandom(32'h3aa3_fe14));
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        nRST = 1'b1;
        idle(3);
        check("reset display", 32'd0, 32'($unsigned(display_output)));
        check("reset complete", 32'd0, 32'(complete));

        run_operation("add 0+0", 0, 0, OP_ADD, 1'b0, 1'b0, 1'b0);
        run_operation("add 12+34", 12, 34, OP_ADD, 1'b0, 1'b0, 1'b0);
        run_operation("add 65535+1", 65535, 1, OP_ADD, 1'b0, 1'b0, 1'b0);
        run_operation("sub 3-7", 3, 7, OP_SUB, 1'b0, 1'b0, 1'b0);
        check("sub 3-7 signed", 32'hffff_fffc, 32'($signed(display_output)));
        run_operation("sub 500-123", 500, 123, OP_SUB, 1'b0, 1'b0, 1'b0);
        run_operation("mul 9999*6", 9999, 6, OP_MUL, 1'b0, 1'b0, 1'b0);
        run_operation("mul 1234*567", 1234, 567, OP_MUL, 1'b0, 1'b0, 1'b0);
        run_operation("junk digits 45+78", 45, 78, OP_ADD, 1'b1, 1'b0, 1'b0);
        run_operation("invalid op then 90-15", 90, 15, OP_SUB, 1'b0, 1'b1, 1'b0);
        run_operation("early equal then 12*12", 12, 12, OP_MUL, 1'b0, 1'b0, 1'b1);

        for (int i = 0; i < RANDOM_OPS; i++) begin
            name = $sformatf("random op %0d", i);
            run_operation(name, random_operand(), random_operand(), random_operator(),
                          1'b0, 1'b0, 1'b0);
        end

        idle(5);
        if (exp_values.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run("Some operations ended without a matching result");
        end
    end

endmodule

`default_nettype wire

//--- sources.f
hw/calc_pkg.sv
hw/keypad_entry.sv
hw/calc_sequencer.sv
hw/serial_add_sub.sv
hw/shift_add_multiplier.sv
hw/result_display.sv
hw/calculator_top.sv
dv/calculator_tb.sv
